/* logic/audio_pkg.sv */
package audio_pkg;

  // frame and bit clock timing, all in audio_clk cycles
  localparam int FRAME_CYCLES  = 2048;  // 98.3 MHz / 48 kHz
  localparam int BCLK_DIV_LOG  = 5;     // 32 cycles per bclk period
  localparam int SAMPLE_BITS   = 16;
  localparam int MIC_WORD_BITS = 18;    // mic sends 18, we keep the top 16
  localparam int DELAY_DEPTH   = 256;
  localparam int IR_LENGTH     = 64;    // board build uses 24000

  typedef logic signed [SAMPLE_BITS-1:0] audio_sample_t;
  typedef logic [7:0] delay_t;          // delay in frames
  typedef logic [$clog2(IR_LENGTH)-1:0] ir_addr_t;
  typedef logic [5:0] bit_index_t;      // position in the 64-bit frame

  typedef enum logic [1:0] {
    IDLE,
    WAIT_DELAY,
    CAPTURE,
    DONE
  } recorder_state_t;

  typedef struct packed {
    logic       bclk;
    logic       lrcl;
    logic       bit_strobe;  // one cycle at the bclk rising edge
    bit_index_t bit_index;
    logic       frame_tick;
  } i2s_timing_t;

  typedef struct packed {
    logic          valid;
    audio_sample_t data;
  } sample_beat_t;

  typedef struct packed {
    logic          enable;
    ir_addr_t      addr;
    audio_sample_t data;
  } ir_write_t;

endpackage

/* logic/sample_timer.sv */
`timescale 1ns/10ps

module sample_timer (
  input  logic                   audio_clk,
  input  logic                   rst,
  output audio_pkg::i2s_timing_t timing
);
  import audio_pkg::*;

  // one full 48 kHz frame per wrap
  logic [$clog2(FRAME_CYCLES)-1:0] count;
  i2s_timing_t                     timing_next;

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // decode everything from the same count value so the fields stay aligned
  always_comb begin
    timing_next.bclk       = count[BCLK_DIV_LOG-1];
    timing_next.lrcl       = count[$bits(count)-1];  // low = left slot
    // rising edge of bclk is where the low bits reach half a bit period
    timing_next.bit_strobe = count[BCLK_DIV_LOG-1] &&
                             (count[BCLK_DIV_LOG-2:0] == '0);
    timing_next.bit_index  = count[BCLK_DIV_LOG +: $bits(bit_index_t)];
    timing_next.frame_tick = (count == '0);
  end

  // registered so the mic sees clean clocks
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      timing <= '0;
    end else begin
      timing <= timing_next;
    end
  end

endmodule

/* logic/i2s_receiver.sv */
`timescale 1ns/10ps

module i2s_receiver (
  input  logic                    audio_clk,
  input  logic                    rst,
  input  audio_pkg::i2s_timing_t  timing,
  input  logic                    mic_data,
  output audio_pkg::sample_beat_t beat
);
  import audio_pkg::*;

  audio_sample_t shift_q;
  logic          in_window;
  logic          capture;
  logic          last_bit;
  logic          valid_q;

  // bit 0 is the one-bit I2S delay, bits past SAMPLE_BITS are dropped
  assign in_window = (timing.bit_index >= bit_index_t'(1)) &&
                     (timing.bit_index <= bit_index_t'(SAMPLE_BITS));

  // left slot only
  assign capture  = timing.bit_strobe && !timing.lrcl && in_window;
  assign last_bit = capture && (timing.bit_index == bit_index_t'(SAMPLE_BITS));

  // msb first
  always_ff @(posedge audio_clk) begin
    if (capture) begin
      shift_q <= {shift_q[SAMPLE_BITS-2:0], mic_data};
    end
  end

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= last_bit;  // one cycle after the final strobe
    end
  end

  // shift_q holds still until bit 1 of the next frame
  always_comb begin
    beat.valid = valid_q;
    beat.data  = shift_q;
  end

endmodule

/* logic/impulse_recorder.sv */
`timescale 1ns/10ps

module impulse_recorder (
  input  logic                    audio_clk,
  input  logic                    rst,
  input  logic                    record,
  input  audio_pkg::delay_t       delay,
  input  audio_pkg::sample_beat_t beat,
  output audio_pkg::ir_write_t    ir_write,
  output logic                    ir_recorded
);
  import audio_pkg::*;

  recorder_state_t state;
  delay_t          skip_cnt;   // valids already skipped
  ir_addr_t        wr_addr;
  logic            take;       // this valid goes into memory
  logic            last_addr;
  logic            rearm;

  // record restarts only when not in the middle of a capture
  assign rearm = record && ((state == IDLE) || (state == DONE));

  // first sample can land while still in WAIT_DELAY, covers delay 0
  always_comb begin
    take = 1'b0;
    if (beat.valid) begin
      if (state == CAPTURE) begin
        take = 1'b1;
      end else if (state == WAIT_DELAY && skip_cnt >= delay) begin
        take = 1'b1;
      end
    end
  end

  assign last_addr = (wr_addr == ir_addr_t'(IR_LENGTH - 1));

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      state    <= IDLE;
      skip_cnt <= '0;
      wr_addr  <= '0;
    end else if (rearm) begin
      state    <= WAIT_DELAY;
      skip_cnt <= '0;
      wr_addr  <= '0;
    end else if (take) begin
      wr_addr <= wr_addr + 1'b1;
      state   <= last_addr ? DONE : CAPTURE;
    end else if (state == WAIT_DELAY && beat.valid) begin
      skip_cnt <= skip_cnt + 1'b1;
    end
  end

  // writes go straight to the memory port
  always_comb begin
    ir_write.enable = take;
    ir_write.addr   = wr_addr;
    ir_write.data   = beat.data;
  end

  assign ir_recorded = (state == DONE);

endmodule

/* logic/impulse_memory.sv */
`timescale 1ns/10ps

module impulse_memory (
  input  logic                     audio_clk,
  input  audio_pkg::ir_write_t     ir_write,
  input  audio_pkg::ir_addr_t      read_addr,
  output audio_pkg::audio_sample_t read_data
);
  import audio_pkg::*;

  // plain array so the board build can map it to block ram
  audio_sample_t mem [IR_LENGTH];

  always_ff @(posedge audio_clk) begin
    if (ir_write.enable) begin
      mem[ir_write.addr] <= ir_write.data;
    end
  end

  // registered read, one cycle from address to data
  always_ff @(posedge audio_clk) begin
    read_data <= mem[read_addr];
  end

endmodule

/* logic/delay_line.sv */
`timescale 1ns/10ps

module delay_line (
  input  logic                     audio_clk,
  input  logic                     rst,
  input  audio_pkg::sample_beat_t  beat,
  input  audio_pkg::delay_t        delay,
  output audio_pkg::audio_sample_t delayed_sample
);
  import audio_pkg::*;

  audio_sample_t buffer [DELAY_DEPTH];
  delay_t        wr_ptr;
  delay_t        rd_addr;
  delay_t        clear_addr;
  logic          clearing;  // zero fill after reset

  assign rd_addr = wr_ptr - delay;

  // clear walk, done well before the first sample can arrive
  always_ff @(posedge audio_clk) begin
    if (rst) begin
      clearing   <= 1'b1;
      clear_addr <= '0;
    end else if (clearing) begin
      clear_addr <= clear_addr + 1'b1;
      if (clear_addr == delay_t'(DELAY_DEPTH - 1)) begin
        clearing <= 1'b0;
      end
    end
  end

  always_ff @(posedge audio_clk) begin
    if (clearing) begin
      buffer[clear_addr] <= '0;
    end else if (beat.valid) begin
      buffer[wr_ptr] <= beat.data;
    end
  end

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      wr_ptr         <= '0;
      delayed_sample <= '0;
    end else if (beat.valid) begin
      wr_ptr <= wr_ptr + 1'b1;
      // delay 0 bypasses the buffer, the slot is being written now
      delayed_sample <= (delay == '0) ? beat.data : buffer[rd_addr];
    end
  end

endmodule

/* logic/pdm_modulator.sv */
`timescale 1ns/10ps

module pdm_modulator (
  input  logic                     audio_clk,
  input  logic                     rst,
  input  logic                     frame_tick,
  input  audio_pkg::audio_sample_t level,
  output logic                     pdm_out
);
  import audio_pkg::*;

  audio_sample_t          level_q;
  logic [SAMPLE_BITS-1:0] level_u;  // level + 32768
  logic [SAMPLE_BITS-1:0] acc;

  // flip the sign bit to get offset binary
  assign level_u = {~level_q[SAMPLE_BITS-1], level_q[SAMPLE_BITS-2:0]};

  always_ff @(posedge audio_clk) begin
    if (rst) begin
      level_q <= '0;
      acc     <= '0;
      pdm_out <= 1'b0;
    end else begin
      if (frame_tick) begin
        level_q <= level;  // hold for the whole frame
      end
      {pdm_out, acc} <= acc + level_u;  // carry out is the pdm bit
    end
  end

endmodule

/* logic/audio_echo_top.sv */
`timescale 1ns/10ps

module audio_echo_top (
  input  logic                     audio_clk,
  input  logic                     rst,
  input  logic                     mic_data,
  input  logic                     record,
  input  audio_pkg::delay_t        delay,
  input  audio_pkg::ir_addr_t      ir_read_addr,
  output logic                     bclk,
  output logic                     lrcl,
  output audio_pkg::audio_sample_t sample,
  output logic                     sample_valid,
  output audio_pkg::audio_sample_t delayed_sample,
  output logic                     ir_recorded,
  output audio_pkg::audio_sample_t ir_read_data,
  output logic                     pdm_out
);
  import audio_pkg::*;

  i2s_timing_t  timing;
  sample_beat_t beat;
  ir_write_t    ir_write;

  sample_timer timer_i (
    .audio_clk (audio_clk),
    .rst       (rst),
    .timing    (timing)
  );

  // mic clocks out to the pins
  assign bclk = timing.bclk;
  assign lrcl = timing.lrcl;

  i2s_receiver receiver_i (
    .audio_clk (audio_clk),
    .rst       (rst),
    .timing    (timing),
    .mic_data  (mic_data),
    .beat      (beat)
  );

  assign sample       = beat.data;
  assign sample_valid = beat.valid;

  impulse_recorder recorder_i (
    .audio_clk   (audio_clk),
    .rst         (rst),
    .record      (record),
    .delay       (delay),
    .beat        (beat),
    .ir_write    (ir_write),
    .ir_recorded (ir_recorded)
  );

  impulse_memory memory_i (
    .audio_clk (audio_clk),
    .ir_write  (ir_write),
    .read_addr (ir_read_addr),
    .read_data (ir_read_data)
  );

  delay_line delay_i (
    .audio_clk      (audio_clk),
    .rst            (rst),
    .beat           (beat),
    .delay          (delay),
    .delayed_sample (delayed_sample)
  );

  // speaker gets the echoed signal
  pdm_modulator pdm_i (
    .audio_clk  (audio_clk),
    .rst        (rst),
    .frame_tick (timing.frame_tick),
    .level      (delayed_sample),
    .pdm_out    (pdm_out)
  );

endmodule

/* sim/audio_checker.sv */
`timescale 1ns/10ps

module audio_checker (
  input  logic                     audio_clk,
  input  logic                     rst,
  input  logic [17:0]              mic_word,
  input  logic                     word_start,
  input  logic                     record,
  input  audio_pkg::delay_t        delay,
  input  audio_pkg::ir_addr_t      ir_read_addr,
  input  logic                     bclk,
  input  logic                     lrcl,
  input  audio_pkg::audio_sample_t sample,
  input  logic                     sample_valid,
  input  audio_pkg::audio_sample_t delayed_sample,
  input  logic                     ir_recorded,
  input  audio_pkg::audio_sample_t ir_read_data,
  input  logic                     pdm_out,
  output int                       mismatches,
  output int                       failures,
  output int                       ir_done
);
  import audio_pkg::*;

  audio_sample_t   expected_q[$];
  audio_sample_t   hist [DELAY_DEPTH];     // past samples by valid count
  delay_t          hist_wp;
  audio_sample_t   model_mem [IR_LENGTH];
  recorder_state_t rec_state;
  int              skipped;
  int              rec_addr;
  logic            beat_valid;
  audio_sample_t   beat_data;
  logic            delay_pending;
  audio_sample_t   delay_expect;
  logic            read_pending;
  ir_addr_t        read_addr_q;
  logic            rst_q = 1'b0;
  logic            lrcl_q = 1'b0;
  logic            b1 = 1'b0;
  logic            b2 = 1'b0;             // boundary seen two cycles late
  logic            win_active = 1'b0;
  audio_sample_t   lvl_seen;
  audio_sample_t   lvl_win;
  int              ones;
  int              windows = 0;

  initial begin
    mismatches = 0;
    failures   = 0;
    ir_done    = 0;
  end

  task automatic report_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
    $display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
    mismatches++;
  endtask

  task automatic store_sample(input audio_sample_t s);
    model_mem[rec_addr] = s;
    rec_addr++;
    if (rec_addr == IR_LENGTH) begin
      rec_state = DONE;
      ir_done++;
    end else begin
      rec_state = CAPTURE;
    end
  endtask

  task automatic update_recorder();
    if (record && (rec_state == IDLE || rec_state == DONE)) begin
      rec_state = WAIT_DELAY;
      skipped   = 0;
      rec_addr  = 0;
    end else if (beat_valid && rec_state == CAPTURE) begin
      store_sample(beat_data);
    end else if (beat_valid && rec_state == WAIT_DELAY) begin
      if (skipped >= int'(delay)) begin
        store_sample(beat_data);
      end else begin
        skipped++;
      end
    end
  endtask

  // pdm window runs two cycles behind the frame edge to line up with the level load
  task automatic check_pdm();
    int lu;
    if (b2) begin
      if (win_active && windows >= 2) begin
        lu = int'(lvl_win) + 32768;
        if (ones * 32 - lu > 32 || lu - ones * 32 > 32) begin
          report_mismatch("pdm_out ones", 16'(lu / 32), 16'(ones));
        end
      end
      if (win_active) begin
        windows++;
      end
      win_active = 1'b1;
      ones       = 0;
      lvl_win    = lvl_seen;
    end
    if (win_active && pdm_out) begin
      ones++;
    end
    b2 = b1;
    b1 = lrcl_q && !lrcl && !bclk;
    if (b1) begin
      lvl_seen = delayed_sample;
    end
    lrcl_q = lrcl;
  endtask

  always @(posedge audio_clk) begin
    if (rst_q) begin  // during reset and one cycle after
      if (sample_valid !== 1'b0) report_mismatch("sample_valid", 16'h0, 16'(sample_valid));
      if (ir_recorded !== 1'b0) report_mismatch("ir_recorded", 16'h0, 16'(ir_recorded));
      if (pdm_out !== 1'b0) report_mismatch("pdm_out", 16'h0, 16'(pdm_out));
    end
    rst_q = rst;
    if (rst) begin
      expected_q.delete();
      foreach (hist[i]) hist[i] = '0;
      hist_wp       = '0;
      rec_state     = IDLE;
      skipped       = 0;
      rec_addr      = 0;
      delay_pending = 1'b0;
      read_pending  = 1'b0;
    end else begin
      if (delay_pending && delayed_sample !== delay_expect) begin
        report_mismatch("delayed_sample", delay_expect, delayed_sample);
      end
      delay_pending = 1'b0;
      if (read_pending && ir_read_data !== model_mem[read_addr_q]) begin
        report_mismatch("ir_read_data", model_mem[read_addr_q], ir_read_data);
      end
      read_pending = (rec_state == DONE);
      read_addr_q  = ir_read_addr;
      if (ir_recorded !== (rec_state == DONE)) begin
        report_mismatch("ir_recorded", 16'(rec_state == DONE), 16'(ir_recorded));
      end
      if (word_start) begin
        expected_q.push_back(mic_word[17:2]);  // top 16 of 18 bits
      end
      beat_valid = (sample_valid === 1'b1);
      if (beat_valid) begin
        if (expected_q.size() == 0) begin
          $display("sample_valid arrived with no microphone word sent at %0t", $time);
          failures++;
          beat_data = sample;
        end else begin
          beat_data = expected_q.pop_front();
          if (sample !== beat_data) report_mismatch("sample", beat_data, sample);
        end
        hist[hist_wp] = beat_data;
        delay_expect  = hist[delay_t'(hist_wp - delay)];  // delay 0 is this sample
        hist_wp       = hist_wp + 8'd1;
        delay_pending = 1'b1;
      end
      update_recorder();
      check_pdm();
    end
  end

endmodule

/* sim/tb_audio_echo.sv */
`timescale 1ns/10ps

module tb_audio_echo;
  import audio_pkg::*;

  localparam int RUN_FRAMES  = 330;
  localparam int CYCLE_LIMIT = RUN_FRAMES * FRAME_CYCLES + 4096;

  logic          audio_clk;
  logic          rst;
  logic          mic_data;
  logic          record;
  delay_t        delay;
  ir_addr_t      ir_read_addr;
  logic          bclk;
  logic          lrcl;
  audio_sample_t sample;
  logic          sample_valid;
  audio_sample_t delayed_sample;
  logic          ir_recorded;
  audio_sample_t ir_read_data;
  logic          pdm_out;

  logic [31:0]              lcg_state;
  logic [MIC_WORD_BITS-1:0] mic_word;
  logic                     word_start;
  logic                     bclk_q;
  logic                     lrcl_q;
  logic                     started;
  int                       pos;
  int                       frame_num;
  int                       cycles = 0;
  int                       timeouts = 0;
  int                       mismatches;
  int                       failures;
  int                       ir_done;
  logic                     swept;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [MIC_WORD_BITS-1:0] random_word();
    logic [31:0] r;
    r = lcg_next();
    return r[31:14];
  endfunction

  function automatic delay_t random_delay();
    logic [31:0] r;
    r = lcg_next();
    return delay_t'(r[31:16] % 16'd13);  // 0 to 12 frames
  endfunction

  audio_echo_top dut_i (
    .audio_clk      (audio_clk),
    .rst            (rst),
    .mic_data       (mic_data),
    .record         (record),
    .delay          (delay),
    .ir_read_addr   (ir_read_addr),
    .bclk           (bclk),
    .lrcl           (lrcl),
    .sample         (sample),
    .sample_valid   (sample_valid),
    .delayed_sample (delayed_sample),
    .ir_recorded    (ir_recorded),
    .ir_read_data   (ir_read_data),
    .pdm_out        (pdm_out)
  );

  audio_checker checker_i (
    .audio_clk      (audio_clk),
    .rst            (rst),
    .mic_word       (mic_word),
    .word_start     (word_start),
    .record         (record),
    .delay          (delay),
    .ir_read_addr   (ir_read_addr),
    .bclk           (bclk),
    .lrcl           (lrcl),
    .sample         (sample),
    .sample_valid   (sample_valid),
    .delayed_sample (delayed_sample),
    .ir_recorded    (ir_recorded),
    .ir_read_data   (ir_read_data),
    .pdm_out        (pdm_out),
    .mismatches     (mismatches),
    .failures       (failures),
    .ir_done        (ir_done)
  );

  always #2 audio_clk = ~audio_clk;

  // microphone model shifts a new bit out on each bclk falling edge
  always @(posedge audio_clk) begin
    word_start <= 1'b0;
    if (rst) begin
      bclk_q    <= 1'b0;
      lrcl_q    <= 1'b0;
      pos       <= 0;
      mic_data  <= 1'b0;
      started   <= 1'b0;
      frame_num <= 0;
    end else begin
      bclk_q <= bclk;
      lrcl_q <= lrcl;
      if (!started) begin
        started    <= 1'b1;
        mic_word   <= random_word();
        word_start <= 1'b1;
      end
      if (bclk_q && !bclk) begin
        if (lrcl_q && !lrcl) begin  // bit 0 of a new frame is the delay bit
          pos        <= 0;
          mic_data   <= 1'b0;
          mic_word   <= random_word();
          word_start <= 1'b1;
          frame_num  <= frame_num + 1;
        end else begin
          pos      <= pos + 1;
          mic_data <= (!lrcl && pos + 1 <= MIC_WORD_BITS) ?
                      mic_word[MIC_WORD_BITS-1-pos] : 1'b0;
        end
      end
    end
  end

  task automatic sweep_memory();
    for (int a = 0; a < IR_LENGTH; a++) begin
      ir_read_addr <= ir_addr_t'(a);
      @(posedge audio_clk);
    end
  endtask

  task automatic finish_run();
    int no_rec;
    no_rec = 0;
    if (ir_done == 0) begin
      $display("no impulse recording completed during the run");
      no_rec = 1;
    end
    $display("errors: mismatches %0d, other failures %0d, timeouts %0d",
             mismatches, failures + no_rec, timeouts);
    if (mismatches + failures + no_rec + timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  initial begin
    int last;
    audio_clk    = 1'b0;
    rst          = 1'b1;
    mic_data     = 1'b0;
    record       = 1'b0;
    ir_read_addr = '0;
    lcg_state    = 32'd26228;
    swept        = 1'b0;
    delay        = random_delay();
    repeat (4) @(posedge audio_clk);
    rst <= 1'b0;
    while (frame_num < RUN_FRAMES) begin
      last = frame_num;
      while (frame_num == last) @(posedge audio_clk);
      repeat (8) @(posedge audio_clk);  // well clear of the sample valid
      if (frame_num % 40 == 0) begin
        delay <= random_delay();
      end
      if (ir_recorded && !swept) begin
        sweep_memory();
        swept = 1'b1;
      end
      if (frame_num == 3 || lcg_next() % 8 == 0) begin
        record <= 1'b1;
        @(posedge audio_clk);
        record <= 1'b0;
        swept = 1'b0;
      end
    end
    repeat (8) @(posedge audio_clk);
    @(negedge audio_clk);
    finish_run();
  end

  always @(posedge audio_clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      timeouts = 1;
      finish_run();
    end
  end

endmodule

/* vlog.f */
logic/audio_pkg.sv
logic/sample_timer.sv
logic/i2s_receiver.sv
logic/impulse_recorder.sv
logic/impulse_memory.sv
logic/delay_line.sv
logic/pdm_modulator.sv
logic/audio_echo_top.sv
sim/audio_checker.sv
sim/tb_audio_echo.sv

/* Makefile */
# Verilator build and run of the audio echo testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   list these targets"

test:
	verilator --binary --timing -f vlog.f --top-module tb_audio_echo -o sim_audio_echo
	./obj_dir/sim_audio_echo > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
	  echo "simulation reported failure"; exit 1; fi
	@if ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
	  echo "simulation did not report a pass"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
